// File: hw/decode_stage.sv
`default_nettype none

`include "rv_core_defs.svh"

module decode_stage (
  input  wire logic                clk,
  input  wire logic                arst_n_i,
  input  wire logic                valid_i,
  input  wire rv_core_pkg::xlen_t  pc_i,
  input  wire rv_core_pkg::instr_t instr_i,
  input  wire logic                flush_i,
  wb_bus_if.dst                    wb,
  ex_bus_if.src                    ex,
  output rv_core_pkg::xlen_t       reg_a0_o
);
  import rv_core_pkg::*;

  xlen_t    regs [`RV_NREGS];
  logic     [6:0] opcode;
  logic     [2:0] funct3;
  reg_idx_t rs1_idx;
  reg_idx_t rs2_idx;
  reg_idx_t rd_idx;
  logic     wb_wr;
  xlen_t    rs1_val;
  xlen_t    rs2_val;

  alu_op_e  dec_alu_op;
  xlen_t    dec_imm;
  logic     dec_use_imm;
  logic     dec_wb_en;
  logic     dec_is_branch;
  logic     dec_branch_ne;
  logic     dec_is_jal;

  // shared between OP and OP-IMM, alt selects sub / sra
  function automatic alu_op_e f3_to_alu(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      `RV_F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
      `RV_F3_SLL:     op = ALU_SLL;
      `RV_F3_SLT:     op = ALU_SLT;
      `RV_F3_SLTU:    op = ALU_SLTU;
      `RV_F3_XOR:     op = ALU_XOR;
      `RV_F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
      `RV_F3_OR:      op = ALU_OR;
      default:        op = ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode  = instr_i[6:0];
  assign funct3  = instr_i[14:12];
  assign rd_idx  = instr_i[11:7];
  assign rs1_idx = instr_i[19:15];
  assign rs2_idx = instr_i[24:20];

  always_comb begin
    dec_alu_op    = ALU_ADD;
    dec_imm       = {{20{instr_i[31]}}, instr_i[31:20]};  // I-type
    dec_use_imm   = 1'b0;
    dec_wb_en     = 1'b0;  // unknown opcodes write nothing
    dec_is_branch = 1'b0;
    dec_branch_ne = 1'b0;
    dec_is_jal    = 1'b0;
    case (opcode)
      `RV_OPC_OP: begin
        dec_alu_op = f3_to_alu(funct3, instr_i[30]);
        dec_wb_en  = 1'b1;
      end
      `RV_OPC_OP_IMM: begin
        // bit 30 is only an opcode bit for the right shifts
        dec_alu_op  = f3_to_alu(funct3, (funct3 == `RV_F3_SRL_SRA) && instr_i[30]);
        dec_use_imm = 1'b1;
        dec_wb_en   = 1'b1;
      end
      `RV_OPC_LUI: begin
        dec_alu_op  = ALU_PASS_IMM;
        dec_imm     = {instr_i[31:12], 12'b0};
        dec_use_imm = 1'b1;
        dec_wb_en   = 1'b1;
      end
      `RV_OPC_BRANCH: begin
        dec_imm       = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                         instr_i[30:25], instr_i[11:8], 1'b0};
        dec_is_branch = (funct3 == `RV_F3_BEQ) || (funct3 == `RV_F3_BNE);
        dec_branch_ne = (funct3 == `RV_F3_BNE);
      end
      `RV_OPC_JAL: begin
        dec_imm    = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12],
                      instr_i[20], instr_i[30:21], 1'b0};
        dec_is_jal = 1'b1;
        dec_wb_en  = 1'b1;  // link is pc + 4
      end
      default: ;
    endcase
  end

  // register file, written from the wb register
  assign wb_wr = wb.valid && wb.wb_en && (wb.rd_idx != '0);

  always_ff @(posedge clk) begin
    if (wb_wr) regs[wb.rd_idx] <= wb.result;
  end

  // write-through so the word written this cycle is seen now
  always_comb begin
    rs1_val = regs[rs1_idx];
    if (wb_wr && (wb.rd_idx == rs1_idx)) rs1_val = wb.result;
    if (rs1_idx == '0) rs1_val = '0;
    rs2_val = regs[rs2_idx];
    if (wb_wr && (wb.rd_idx == rs2_idx)) rs2_val = wb.result;
    if (rs2_idx == '0) rs2_val = '0;
  end

  assign reg_a0_o = regs[10];  // a0 is x10

  // decode to execute register
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ex.valid <= 1'b0;
    end else begin
      ex.valid <= valid_i && !flush_i;
    end
  end

  always_ff @(posedge clk) begin
    ex.pc        <= pc_i;
    ex.rs1_idx   <= rs1_idx;
    ex.rs2_idx   <= rs2_idx;
    ex.rs1_val   <= rs1_val;
    ex.rs2_val   <= rs2_val;
    ex.imm       <= dec_imm;
    ex.alu_op    <= dec_alu_op;
    ex.use_imm   <= dec_use_imm;
    ex.rd_idx    <= rd_idx;
    ex.wb_en     <= dec_wb_en;
    ex.is_branch <= dec_is_branch;
    ex.branch_ne <= dec_branch_ne;
    ex.is_jal    <= dec_is_jal;
  end

endmodule

`default_nettype wire

// File: hw/execute_stage.sv
`default_nettype none

module execute_stage (
  input  wire logic          clk,
  input  wire logic          arst_n_i,
  ex_bus_if.dst              ex,
  wb_bus_if.src              wb,
  output logic               redirect_o,
  output rv_core_pkg::xlen_t target_o
);
  import rv_core_pkg::*;

  logic  wb_fwd_ok;
  xlen_t op_a;
  xlen_t rs2_fwd;
  xlen_t op_b;
  logic  [4:0] shamt;
  xlen_t alu_res;
  xlen_t link_pc;
  logic  operands_eq;
  logic  br_taken;

  // forwarding from the wb register, x0 never forwarded
  assign wb_fwd_ok = wb.valid && wb.wb_en && (wb.rd_idx != '0);

  assign op_a    = (wb_fwd_ok && (wb.rd_idx == ex.rs1_idx)) ? wb.result : ex.rs1_val;
  assign rs2_fwd = (wb_fwd_ok && (wb.rd_idx == ex.rs2_idx)) ? wb.result : ex.rs2_val;
  assign op_b    = ex.use_imm ? ex.imm : rs2_fwd;
  assign shamt   = op_b[4:0];

  always_comb begin
    case (ex.alu_op)
      ALU_ADD:      alu_res = op_a + op_b;
      ALU_SUB:      alu_res = op_a - op_b;
      ALU_AND:      alu_res = op_a & op_b;
      ALU_OR:       alu_res = op_a | op_b;
      ALU_XOR:      alu_res = op_a ^ op_b;
      ALU_SLT:      alu_res = xlen_t'($signed(op_a) < $signed(op_b));
      ALU_SLTU:     alu_res = xlen_t'(op_a < op_b);
      ALU_SLL:      alu_res = op_a << shamt;
      ALU_SRL:      alu_res = op_a >> shamt;
      ALU_SRA:      alu_res = xlen_t'($signed(op_a) >>> shamt);
      ALU_PASS_IMM: alu_res = ex.imm;  // lui
      default:      alu_res = '0;
    endcase
  end

  assign link_pc = ex.pc + xlen_t'(4);

  // branch compare uses the forwarded rs2, not the immediate
  assign operands_eq = (op_a == rs2_fwd);
  assign br_taken    = ex.is_branch && (ex.branch_ne ? !operands_eq : operands_eq);

  assign redirect_o = ex.valid && (br_taken || ex.is_jal);
  assign target_o   = ex.pc + ex.imm;

  // writeback register
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wb.valid <= 1'b0;
    end else begin
      wb.valid <= ex.valid;
    end
  end

  always_ff @(posedge clk) begin
    wb.pc     <= ex.pc;
    wb.rd_idx <= ex.rd_idx;
    wb.wb_en  <= ex.wb_en;
    wb.result <= ex.is_jal ? link_pc : alu_res;
  end

endmodule

`default_nettype wire

// File: hw/fetch_unit.sv
`default_nettype none

`include "rv_core_defs.svh"

module fetch_unit (
  input  wire logic               clk,
  input  wire logic               arst_n_i,
  input  wire rv_core_pkg::instr_t instr_i,
  input  wire logic               instr_valid_i,
  input  wire logic               redirect_i,
  input  wire rv_core_pkg::xlen_t target_i,
  input  wire logic               discard_i,
  output logic                    fetch_req_o,
  output rv_core_pkg::xlen_t      fetch_addr_o,
  output logic                    id_valid_o,
  output rv_core_pkg::xlen_t      id_pc_o,
  output rv_core_pkg::instr_t     id_instr_o
);
  import rv_core_pkg::*;

  xlen_t pc_q;
  xlen_t redir_pc_q;  // target parked while a stale word is pending
  logic  accept;

  assign fetch_req_o  = 1'b1;  // no back-pressure, always asking
  assign fetch_addr_o = pc_q;
  assign accept       = fetch_req_o && instr_valid_i;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_q <= `RV_RESET_PC;
    end else if (redirect_i) begin
      // outstanding request keeps its address until answered
      if (accept) pc_q <= target_i;
    end else if (accept) begin
      if (discard_i) pc_q <= redir_pc_q;  // stale word dropped, go to target
      else           pc_q <= pc_q + xlen_t'(4);
    end
  end

  always_ff @(posedge clk) begin
    if (redirect_i) redir_pc_q <= target_i;
  end

  // fetch to decode register
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      id_valid_o <= 1'b0;
    end else begin
      id_valid_o <= accept && !redirect_i && !discard_i;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      id_pc_o    <= pc_q;
      id_instr_o <= instr_i;
    end
  end

endmodule

`default_nettype wire

// File: hw/pipeline_ctrl.sv
`default_nettype none

module pipeline_ctrl (
  input  wire logic clk,
  input  wire logic arst_n_i,
  input  wire logic redirect_i,
  input  wire logic fetch_req_i,
  input  wire logic instr_valid_i,
  output logic      flush_id_o,
  output logic      discard_o
);
  import rv_core_pkg::*;

  fetch_state_e state_q;
  fetch_state_e state_d;

  // younger instruction in decode is wrong-path
  assign flush_id_o = redirect_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      FETCH_RUN: begin
        // request still pending at the redirect, its word must be dropped
        if (redirect_i && fetch_req_i && !instr_valid_i) state_d = FETCH_DISCARD;
      end
      FETCH_DISCARD: begin
        if (fetch_req_i && instr_valid_i) state_d = FETCH_RUN;
      end
      default: state_d = FETCH_RUN;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= FETCH_RUN;
    end else begin
      state_q <= state_d;
    end
  end

  assign discard_o = (state_q == FETCH_DISCARD);

endmodule

`default_nettype wire

// File: hw/rv_core_defs.svh
`ifndef RV_CORE_DEFS_SVH
`define RV_CORE_DEFS_SVH

// datapath widths
`define RV_XLEN      32
`define RV_ILEN      32
`define RV_NREGS     32
`define RV_RESET_PC  32'h0000_0000

// major opcodes, instr[6:0]
`define RV_OPC_OP      7'b0110011
`define RV_OPC_OP_IMM  7'b0010011
`define RV_OPC_LUI     7'b0110111
`define RV_OPC_BRANCH  7'b1100011
`define RV_OPC_JAL     7'b1101111

// funct3 values
`define RV_F3_ADD_SUB  3'b000
`define RV_F3_SLL      3'b001
`define RV_F3_SLT      3'b010
`define RV_F3_SLTU     3'b011
`define RV_F3_XOR      3'b100
`define RV_F3_SRL_SRA  3'b101
`define RV_F3_OR       3'b110
`define RV_F3_AND      3'b111
`define RV_F3_BEQ      3'b000
`define RV_F3_BNE      3'b001

`endif

// File: hw/rv_core_if.sv
`default_nettype none

// decode to execute
interface ex_bus_if;
  import rv_core_pkg::*;

  logic     valid;
  xlen_t    pc;
  reg_idx_t rs1_idx;
  reg_idx_t rs2_idx;
  xlen_t    rs1_val;
  xlen_t    rs2_val;
  xlen_t    imm;
  alu_op_e  alu_op;
  logic     use_imm;   // operand b from imm
  reg_idx_t rd_idx;
  logic     wb_en;
  logic     is_branch;
  logic     branch_ne; // bne when set, else beq
  logic     is_jal;

  modport src (output valid, pc, rs1_idx, rs2_idx, rs1_val, rs2_val, imm, alu_op,
               use_imm, rd_idx, wb_en, is_branch, branch_ne, is_jal);
  modport dst (input valid, pc, rs1_idx, rs2_idx, rs1_val, rs2_val, imm, alu_op,
               use_imm, rd_idx, wb_en, is_branch, branch_ne, is_jal);
endinterface

// execute to writeback
interface wb_bus_if;
  import rv_core_pkg::*;

  logic     valid;
  xlen_t    pc;
  reg_idx_t rd_idx;
  logic     wb_en;
  xlen_t    result;

  modport src (output valid, pc, rd_idx, wb_en, result);
  modport dst (input valid, pc, rd_idx, wb_en, result);
endinterface

`default_nettype wire

// File: hw/rv_core_pkg.sv
`default_nettype none

`include "rv_core_defs.svh"

package rv_core_pkg;

  typedef logic [`RV_XLEN-1:0]            xlen_t;
  typedef logic [`RV_ILEN-1:0]            instr_t;
  typedef logic [$clog2(`RV_NREGS)-1:0]   reg_idx_t;

  // alu operations, lui just passes the immediate
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_PASS_IMM
  } alu_op_e;

  // fetch control
  typedef enum logic {
    FETCH_RUN,      // normal fetching
    FETCH_DISCARD   // waiting to drop a stale word
  } fetch_state_e;

endpackage

`default_nettype wire

// File: hw/rv_core_top.sv
`default_nettype none

module rv_core_top (
  input  wire logic                clk,
  input  wire logic                arst_n_i,
  input  wire rv_core_pkg::instr_t instr_i,
  input  wire logic                instr_valid_i,
  output logic                     fetch_req_o,
  output rv_core_pkg::xlen_t       fetch_addr_o,
  output logic                     retire_valid_o,
  output rv_core_pkg::xlen_t       retire_pc_o,
  output rv_core_pkg::reg_idx_t    retire_rd_o,
  output rv_core_pkg::xlen_t       retire_data_o,
  output rv_core_pkg::xlen_t       reg_a0_o
);
  import rv_core_pkg::*;

  logic   id_valid;
  xlen_t  id_pc;
  instr_t id_instr;
  logic   redirect;
  xlen_t  target;
  logic   flush_id;
  logic   discard;

  ex_bus_if u_ex_bus ();
  wb_bus_if u_wb_bus ();

  fetch_unit u_fetch (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .instr_i       (instr_i),
    .instr_valid_i (instr_valid_i),
    .redirect_i    (redirect),
    .target_i      (target),
    .discard_i     (discard),
    .fetch_req_o   (fetch_req_o),
    .fetch_addr_o  (fetch_addr_o),
    .id_valid_o    (id_valid),
    .id_pc_o       (id_pc),
    .id_instr_o    (id_instr)
  );

  decode_stage u_decode (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .valid_i  (id_valid),
    .pc_i     (id_pc),
    .instr_i  (id_instr),
    .flush_i  (flush_id),
    .wb       (u_wb_bus.dst),
    .ex       (u_ex_bus.src),
    .reg_a0_o (reg_a0_o)
  );

  execute_stage u_execute (
    .clk        (clk),
    .arst_n_i   (arst_n_i),
    .ex         (u_ex_bus.dst),
    .wb         (u_wb_bus.src),
    .redirect_o (redirect),
    .target_o   (target)
  );

  pipeline_ctrl u_ctrl (
    .clk           (clk),
    .arst_n_i      (arst_n_i),
    .redirect_i    (redirect),
    .fetch_req_i   (fetch_req_o),
    .instr_valid_i (instr_valid_i),
    .flush_id_o    (flush_id),
    .discard_o     (discard)
  );

  // retire port mirrors the wb register
  assign retire_valid_o = u_wb_bus.valid;
  assign retire_pc_o    = u_wb_bus.pc;
  assign retire_rd_o    = u_wb_bus.wb_en ? u_wb_bus.rd_idx : '0;  // zero for branches
  assign retire_data_o  = u_wb_bus.wb_en ? u_wb_bus.result : '0;

endmodule

`default_nettype wire

// File: tb.f
+incdir+hw
hw/rv_core_pkg.sv
hw/rv_core_if.sv
hw/fetch_unit.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/pipeline_ctrl.sv
hw/rv_core_top.sv
tb/tb_rv_core.sv

// File: tb/rv_core_vectors.hex
// words @00..@3f are the program, @40 is the retire count
// then one retire per line as pc rd data, and last the final a0
@00
123450B7  // lui   x1, 0x12345
67808093  // addi  x1, x1, 0x678
FF000113  // addi  x2, x0, -16
00500193  // addi  x3, x0, 5
00310233  // add   x4, x2, x3
402182B3  // sub   x5, x3, x2
0020F333  // and   x6, x1, x2
0030E3B3  // or    x7, x1, x3
0020C433  // xor   x8, x1, x2
003124B3  // slt   x9, x2, x3
003135B3  // sltu  x11, x2, x3
00319633  // sll   x12, x3, x3
003156B3  // srl   x13, x2, x3
40315733  // sra   x14, x2, x3
0FF0F793  // andi  x15, x1, 0xff
7001E813  // ori   x16, x3, 0x700
FFF1C893  // xori  x17, x3, -1
FF112913  // slti  x18, x2, -15
FFF1B993  // sltiu x19, x3, -1
01C19A13  // slli  x20, x3, 28
00415A93  // srli  x21, x2, 4
40215B13  // srai  x22, x2, 2
00318BB3  // add   x23, x3, x3
017B8BB3  // add   x23, x23, x23
003B8BB3  // add   x23, x23, x3
00718013  // addi  x0, x3, 7
00300C33  // add   x24, x0, x3
003C0663  // beq   x24, x3, +12
00100C93  // addi  x25, x0, 1   skipped
00200C93  // addi  x25, x0, 2   skipped
00311663  // bne   x2, x3, +12
00300C93  // addi  x25, x0, 3   skipped
00400C93  // addi  x25, x0, 4   skipped
00C00D6F  // jal   x26, +12
00500C93  // addi  x25, x0, 5   skipped
00600C93  // addi  x25, x0, 6   skipped
01AB8533  // add   x10, x23, x26
0000006F  // jal   x0, 0   parks the core
@40
00000020
00000000 00000001 12345000
00000004 00000001 12345678
00000008 00000002 FFFFFFF0
0000000C 00000003 00000005
00000010 00000004 FFFFFFF5
00000014 00000005 00000015
00000018 00000006 12345670
0000001C 00000007 1234567D
00000020 00000008 EDCBA988
00000024 00000009 00000001
00000028 0000000B 00000000
0000002C 0000000C 000000A0
00000030 0000000D 07FFFFFF
00000034 0000000E FFFFFFFF
00000038 0000000F 00000078
0000003C 00000010 00000705
00000040 00000011 FFFFFFFA
00000044 00000012 00000001
00000048 00000013 00000001
0000004C 00000014 50000000
00000050 00000015 0FFFFFFF
00000054 00000016 FFFFFFFC
00000058 00000017 0000000A
0000005C 00000017 00000014
00000060 00000017 00000019
00000064 00000000 0000000C  // write to x0 still retires
00000068 00000018 00000005
0000006C 00000000 00000000  // taken beq
00000078 00000000 00000000  // taken bne
00000084 0000001A 00000088  // jal links pc + 4
00000090 0000000A 000000A1
00000094 00000000 00000098
000000A1  // final a0

// File: tb/tb_rv_core.sv
`default_nettype none

module tb_rv_core;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_PERIOD   = 100;
  localparam int DRIVE_DELAY  = 5;
  localparam int RESET_CYCLES = 10;
  localparam int VEC_WORDS    = 256;
  localparam int PROG_WORDS   = 64;  // program occupies words 0..63
  localparam int TRACE_BASE   = 64;  // retire count then the pc rd data triples

  logic        clk;
  logic        arst_n_i;
  logic [31:0] instr_i;
  logic        instr_valid_i;
  logic        fetch_req_o;
  logic [31:0] fetch_addr_o;
  logic        retire_valid_o;
  logic [31:0] retire_pc_o;
  logic [4:0]  retire_rd_o;
  logic [31:0] retire_data_o;
  logic [31:0] reg_a0_o;

  logic [31:0] vec [VEC_WORDS];
  int          exp_count;
  int          ret_idx;
  int          err_count;
  bit          vectors_ready;

  rv_core_top u_dut (
    .clk            (clk),
    .arst_n_i       (arst_n_i),
    .instr_i        (instr_i),
    .instr_valid_i  (instr_valid_i),
    .fetch_req_o    (fetch_req_o),
    .fetch_addr_o   (fetch_addr_o),
    .retire_valid_o (retire_valid_o),
    .retire_pc_o    (retire_pc_o),
    .retire_rd_o    (retire_rd_o),
    .retire_data_o  (retire_data_o),
    .reg_a0_o       (reg_a0_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic compare_value(input string sig, input logic [31:0] expected,
                               input logic [31:0] actual);
    assert (actual === expected) else begin
      err_count++;
      $display("error at %0d ns: %s expected %h got %h", $time, sig, expected, actual);
    end
  endtask

  task automatic load_vectors();
    int i;
    for (i = 0; i < VEC_WORDS; i++) begin
      vec[i] = {17'h0bad1, i[7:0], 7'h00};  // unknown opcode that varies with the index
    end
    $readmemh("tb/rv_core_vectors.hex", vec);
    exp_count = vec[TRACE_BASE];
    assert (exp_count > 0 && TRACE_BASE + 2 + 3 * exp_count <= VEC_WORDS) else begin
      err_count++;
      $display("the vector file gives no usable retire count");
      exp_count = 0;
    end
    vectors_ready = 1'b1;
  endtask

  // zero is an unknown opcode and is never fetched in a correct run
  function automatic logic [31:0] read_imem(input logic [31:0] addr);
    if (addr[31:2] < PROG_WORDS) return vec[addr[7:2]];
    return 32'h0;
  endfunction

  // instruction memory with a random latency of 0 to 3 cycles per request
  task automatic serve_fetches();
    logic [31:0] req_addr;
    int          wait_cycles;
    bit          busy;
    bit          req_seen;
    busy        = 1'b0;
    req_addr    = '0;
    wait_cycles = 0;
    forever begin
      @(negedge clk);
      req_seen = fetch_req_o;
      @(posedge clk);
      #DRIVE_DELAY;
      if (instr_valid_i && req_seen) begin  // word taken at this edge
        instr_valid_i = 1'b0;
        busy          = 1'b0;
      end
      if (fetch_req_o && !busy) begin
        busy        = 1'b1;
        req_addr    = fetch_addr_o;
        wait_cycles = $urandom_range(3, 0);
      end
      if (busy && !instr_valid_i) begin
        compare_value("fetch_addr_o", req_addr, fetch_addr_o);  // held while pending
        if (wait_cycles == 0) begin
          assert (req_addr[31:2] < PROG_WORDS) else begin
            err_count++;
            $display("fetch from address %h lies outside the program memory", req_addr);
          end
          instr_i       = read_imem(req_addr);
          instr_valid_i = 1'b1;
        end else begin
          wait_cycles--;
        end
      end
    end
  endtask

  task automatic check_retire();
    int base;
    base = TRACE_BASE + 1 + 3 * ret_idx;
    compare_value("retire_pc_o", vec[base], retire_pc_o);
    compare_value("retire_rd_o", vec[base + 1], {27'd0, retire_rd_o});
    compare_value("retire_data_o", vec[base + 2], retire_data_o);
    ret_idx++;
  endtask

  // retire port is registered so it is sampled mid cycle
  always @(negedge clk) begin
    if (arst_n_i && retire_valid_o && ret_idx < exp_count) check_retire();
  end

  initial begin
    arst_n_i      = 1'b0;
    instr_i       = '0;
    instr_valid_i = 1'b0;
    err_count     = 0;
    ret_idx       = 0;
    exp_count     = 0;
    void'($urandom(32'ha41c));
    load_vectors();
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    // core asks for the reset pc and retires nothing
    compare_value("fetch_req_o", 32'h1, {31'd0, fetch_req_o});
    compare_value("fetch_addr_o", 32'h0, fetch_addr_o);
    compare_value("retire_valid_o", 32'h0, {31'd0, retire_valid_o});
    arst_n_i = 1'b1;
    fork
      serve_fetches();
    join_none
    wait (ret_idx >= exp_count);
    repeat (2) @(negedge clk);  // last register write has landed
    compare_value("reg_a0_o", vec[TRACE_BASE + 1 + 3 * exp_count], reg_a0_o);
    $display("retired %0d of %0d expected, %0d errors", ret_idx, exp_count, err_count);
    if (err_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // watchdog allows twenty cycles per expected retire plus slack
  initial begin
    wait (vectors_ready);
    #((exp_count * 20 + 200 + RESET_CYCLES) * CLK_PERIOD);
    $display("timeout: the retire trace did not complete in time");
    $display("retired %0d of %0d expected, %0d errors", ret_idx, exp_count, err_count);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire
